/* Makefile */
VERILATOR  ?= verilator
TOP        := dl_rx_tb
RTL_TOP    := dl_rx_top
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# a $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* common/pcie_dl_pkg.sv */
package pcie_dl_pkg;

  localparam int DW_BITS       = 32;
  localparam int SEQ_BITS      = 12;
  localparam int MAX_TLP_DW    = 32;
  localparam int SLOT_COUNT    = 4;
  localparam int SLOT_BITS     = 3;
  localparam int RAM_ADDR_BITS = 7;
  localparam int WCOUNT_BITS   = 6;
  localparam logic LINK_ACTIVE = 1'b1;

  // fmt/type byte values
  localparam logic [7:0] TLP_MWR32 = 8'h40;
  localparam logic [7:0] TLP_MWR64 = 8'h60;
  localparam logic [7:0] TLP_MSG   = 8'h70;
  localparam logic [7:0] TLP_CPL   = 8'h0A;
  localparam logic [7:0] TLP_CPLD  = 8'h4A;

  typedef enum logic [1:0] {CLASS_P, CLASS_NP, CLASS_CPL} tlp_class_e;

  localparam logic [7:0] DLLP_ACK   = 8'h00;
  localparam logic [7:0] DLLP_FC_P  = 8'h80;
  localparam logic [7:0] DLLP_FC_NP = 8'h90;

  typedef logic [7:0]  hdr_credit_t;
  typedef logic [11:0] data_credit_t;

  localparam hdr_credit_t  FC_HDR_INIT  = 8'd1;
  localparam data_credit_t FC_DATA_INIT = 12'd64;

  // byte 0 (type) sits in the low bits and goes out first
  typedef struct packed {
    logic [3:0]          pad;
    logic [SEQ_BITS-1:0] seq;
    logic [7:0]          rsvd;
    logic [7:0]          dllp_type;
  } dllp_ack_t;

  typedef struct packed {
    logic [3:0]   pad;
    data_credit_t data_fc;
    hdr_credit_t  hdr_fc;
    logic [7:0]   dllp_type;
  } dllp_fc_t;

  typedef union packed {
    dllp_ack_t ack;
    dllp_fc_t  fc;
  } dllp_u;

  // reflected crc-32, 0xEDB88320 is 0x04C11DB7 bit reversed
  function automatic logic [31:0] crc32_dw(input logic [31:0] crc_in, input logic [31:0] data,
                                           input int nbytes);
    logic [31:0] crc;
    crc = crc_in;
    for (int i = 0; i < 4; i++) begin
      if (i < nbytes) begin
        crc = crc ^ {24'h0, data[8*i +: 8]};
        for (int b = 0; b < 8; b++) begin
          crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
        end
      end
    end
    return crc;
  endfunction

  // dllp crc, bit 0 of byte 0 enters first
  function automatic logic [15:0] crc16_dw(input logic [31:0] data);
    logic [15:0] crc;
    logic        fb;
    crc = '1;
    for (int i = 0; i < 32; i++) begin
      fb  = crc[15] ^ data[i];
      crc = {crc[14:0], 1'b0};
      if (fb) begin
        crc = crc ^ 16'h100B;
      end
    end
    return ~crc;
  endfunction

endpackage

/* compile.f */
+incdir+sim
common/pcie_dl_pkg.sv
rx_frame/lcrc32_accum.sv
rx_frame/dl_rx_framer.sv
dllp_tx/dllp_builder.sv
source/rx_buffer_ram.sv
source/tlp_forwarder.sv
source/dl_rx_top.sv
sim/dl_rx_tb.sv

/* dllp_tx/dllp_builder.sv */
`timescale 1ns/10ps

module dllp_builder
  import pcie_dl_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_i,
  input  logic [SEQ_BITS-1:0]    seq_i,
  input  tlp_class_e             class_i,
  input  logic [WCOUNT_BITS-1:0] wcount_i,
  input  logic                   m_dllp_ready_i,
  output logic                   busy_o,
  output logic [DW_BITS-1:0]     m_dllp_data_o,
  output logic [3:0]             m_dllp_keep_o,
  output logic                   m_dllp_valid_o,
  output logic                   m_dllp_last_o
);

  typedef enum logic [2:0] {ST_IDLE, ST_ACK, ST_ACK_CRC, ST_FC, ST_FC_CRC} state_e;

  state_e       state_q;
  hdr_credit_t  ph_q;
  hdr_credit_t  nph_q;
  data_credit_t pd_q;
  data_credit_t npd_q;
  data_credit_t data_cred;
  tlp_class_e   class_q;
  dllp_u        body_q;
  dllp_u        ack_body;
  dllp_u        fc_body;
  logic [15:0]  body_crc;
  logic         xfer;

  // payload credits past a 4 dword header
  assign data_cred = (wcount_i > WCOUNT_BITS'(4)) ?
                     data_credit_t'((wcount_i - WCOUNT_BITS'(4)) >> 2) : '0;

  always_comb begin
    ack_body = '0;
    ack_body.ack.dllp_type = DLLP_ACK;
    ack_body.ack.seq = seq_i;
    fc_body = '0;
    if (class_q == CLASS_P) begin
      fc_body.fc.dllp_type = DLLP_FC_P;
      fc_body.fc.hdr_fc    = ph_q + FC_HDR_INIT;
      fc_body.fc.data_fc   = pd_q + FC_DATA_INIT;
    end else begin
      fc_body.fc.dllp_type = DLLP_FC_NP;
      fc_body.fc.hdr_fc    = nph_q + FC_HDR_INIT;
      fc_body.fc.data_fc   = npd_q + FC_DATA_INIT;
    end
  end

  assign xfer = m_dllp_valid_o && m_dllp_ready_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      ph_q    <= '0;
      pd_q    <= '0;
      nph_q   <= '0;
      npd_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (req_i) begin
            state_q <= ST_ACK;
            if (class_i == CLASS_P) begin
              ph_q <= ph_q + 1'b1;
              pd_q <= pd_q + data_cred;
            end else if (class_i == CLASS_NP) begin
              nph_q <= nph_q + 1'b1;
              npd_q <= npd_q + data_cred;
            end
          end
        end
        ST_ACK: if (xfer) state_q <= ST_ACK_CRC;
        // completions carry no flow-control update
        ST_ACK_CRC: if (xfer) state_q <= (class_q == CLASS_CPL) ? ST_IDLE : ST_FC;
        ST_FC: if (xfer) state_q <= ST_FC_CRC;
        default: if (xfer) state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && req_i) begin
      body_q  <= ack_body;
      class_q <= class_i;
    end else if (state_q == ST_ACK_CRC && xfer) begin
      body_q <= fc_body;
    end
  end

  assign body_crc       = crc16_dw(body_q);
  assign busy_o         = (state_q != ST_IDLE);
  assign m_dllp_valid_o = busy_o;

  always_comb begin
    m_dllp_data_o = body_q;
    m_dllp_keep_o = 4'hF;
    m_dllp_last_o = 1'b0;
    if (state_q == ST_ACK_CRC || state_q == ST_FC_CRC) begin
      m_dllp_data_o = {16'h0, body_crc};
      m_dllp_keep_o = 4'h3;
      m_dllp_last_o = 1'b1;
    end
  end

endmodule

/* rx_frame/dl_rx_framer.sv */
`timescale 1ns/10ps

module dl_rx_framer
  import pcie_dl_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     link_up_i,
  input  logic [DW_BITS-1:0]       s_data_i,
  input  logic                     s_valid_i,
  input  logic                     s_last_i,
  input  logic [DW_BITS-1:0]       lcrc_i,
  input  logic [SLOT_BITS-1:0]     head_i,
  input  logic                     dllp_busy_i,
  output logic                     s_ready_o,
  output logic                     lcrc_clr_o,
  output logic                     lcrc_upd_o,
  output logic                     lcrc_half_o,
  output logic                     wr_en_o,
  output logic [RAM_ADDR_BITS-1:0] wr_addr_o,
  output logic [DW_BITS-1:0]       wr_data_o,
  output logic [SLOT_BITS-1:0]     tail_o,
  output logic                     ack_req_o,
  output logic [SEQ_BITS-1:0]      ack_seq_o,
  output tlp_class_e               ack_class_o,
  output logic [WCOUNT_BITS-1:0]   ack_wcount_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_SEQ, ST_TLP, ST_CHECK} state_e;

  state_e                   state_q;
  logic [SLOT_BITS-1:0]     tail_q;
  logic [SEQ_BITS-1:0]      exp_seq_q;
  logic [SEQ_BITS-1:0]      seq_q;
  logic [WCOUNT_BITS-1:0]   wcount_q;
  logic [DW_BITS-1:0]       rx_lcrc_q;
  tlp_class_e               class_q;
  logic                     too_long_q;
  logic                     full;
  logic                     beat;
  logic                     data_beat;
  logic                     room;
  logic                     frame_good;
  logic [RAM_ADDR_BITS-1:0] slot_base;

  function automatic tlp_class_e classify(input logic [7:0] fmt_type);
    case (fmt_type)
      TLP_MWR32, TLP_MWR64, TLP_MSG: return CLASS_P;
      TLP_CPL, TLP_CPLD: return CLASS_CPL;
      default: return CLASS_NP;
    endcase
  endfunction

  assign full = (tail_q[SLOT_BITS-1] != head_i[SLOT_BITS-1]) &&
                (tail_q[SLOT_BITS-2:0] == head_i[SLOT_BITS-2:0]);
  assign slot_base = RAM_ADDR_BITS'(tail_q[SLOT_BITS-2:0]) * RAM_ADDR_BITS'(MAX_TLP_DW);

  always_comb begin
    case (state_q)
      ST_IDLE: s_ready_o = (link_up_i == LINK_ACTIVE) && !full && !dllp_busy_i;
      ST_SEQ, ST_TLP: s_ready_o = (link_up_i == LINK_ACTIVE);
      default: s_ready_o = 1'b0;
    endcase
  end

  assign beat = s_valid_i && s_ready_o;
  // tlp dwords, the last beat is the lcrc itself
  assign data_beat = beat && (state_q != ST_IDLE) && !s_last_i;
  // offset 0 is reserved for the count word
  assign room = (wcount_q < WCOUNT_BITS'(MAX_TLP_DW - 1));
  assign frame_good = (rx_lcrc_q == lcrc_i) && (seq_q == exp_seq_q) && !too_long_q &&
                      (wcount_q != '0);

  assign lcrc_clr_o  = (state_q == ST_CHECK);
  assign lcrc_upd_o  = (beat && state_q == ST_IDLE) || data_beat;
  assign lcrc_half_o = (state_q == ST_IDLE);

  always_comb begin
    wr_en_o   = data_beat && room;
    wr_addr_o = slot_base + RAM_ADDR_BITS'(wcount_q) + RAM_ADDR_BITS'(1);
    wr_data_o = s_data_i;
    if (state_q == ST_CHECK) begin
      wr_en_o   = frame_good;
      wr_addr_o = slot_base;
      wr_data_o = DW_BITS'(wcount_q);
    end
  end

  assign ack_req_o    = (state_q == ST_CHECK) && frame_good;
  assign ack_seq_o    = seq_q;
  assign ack_class_o  = class_q;
  assign ack_wcount_o = wcount_q;
  assign tail_o       = tail_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      tail_q     <= '0;
      exp_seq_q  <= '0;
      wcount_q   <= '0;
      too_long_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (beat) begin
            wcount_q   <= '0;
            too_long_q <= 1'b0;
            state_q    <= ST_SEQ;
          end
        end
        ST_SEQ, ST_TLP: begin
          if (beat && s_last_i) begin
            state_q <= ST_CHECK;
          end else if (data_beat) begin
            state_q <= ST_TLP;
            if (room) begin
              wcount_q <= wcount_q + 1'b1;
            end else begin
              too_long_q <= 1'b1;
            end
          end
        end
        default: begin
          // one-cycle check, then back for the next frame
          state_q <= ST_IDLE;
          if (frame_good) begin
            tail_q    <= tail_q + 1'b1;
            exp_seq_q <= exp_seq_q + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat && state_q == ST_IDLE) begin
      seq_q <= s_data_i[SEQ_BITS-1:0];
    end
    if (data_beat && state_q == ST_SEQ) begin
      class_q <= classify(s_data_i[31:24]);
    end
    if (beat && s_last_i && state_q != ST_IDLE) begin
      rx_lcrc_q <= s_data_i;
    end
  end

endmodule

/* rx_frame/lcrc32_accum.sv */
`timescale 1ns/10ps

module lcrc32_accum
  import pcie_dl_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               clr_i,
  input  logic               upd_i,
  input  logic               half_i,
  input  logic [DW_BITS-1:0] data_i,
  output logic [DW_BITS-1:0] lcrc_o
);

  logic [DW_BITS-1:0] crc_q;
  int                 nbytes;

  // sequence beat only carries 2 bytes
  assign nbytes = half_i ? 2 : 4;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= '1;
    end else if (clr_i) begin
      crc_q <= '1;
    end else if (upd_i) begin
      crc_q <= crc32_dw(crc_q, data_i, nbytes);
    end
  end

  // value as sent on the wire
  assign lcrc_o = ~crc_q;

endmodule

/* sim/dl_rx_tb_model.svh */
// expected output beats, filled when a good frame has been sent
logic [DW_BITS-1:0] exp_tlp_data[$];
logic               exp_tlp_last[$];
dllp_u              exp_dllp_data[$];
logic [3:0]         exp_dllp_keep[$];
logic               exp_dllp_last[$];

logic [SEQ_BITS-1:0] model_seq;
hdr_credit_t         model_ph;
hdr_credit_t         model_nph;
data_credit_t        model_pd;
data_credit_t        model_npd;

function automatic tlp_class_e class_of(input logic [7:0] fmt_type);
  if (fmt_type == TLP_MWR32 || fmt_type == TLP_MWR64 || fmt_type == TLP_MSG) begin
    return CLASS_P;
  end
  if (fmt_type == TLP_CPL || fmt_type == TLP_CPLD) begin
    return CLASS_CPL;
  end
  return CLASS_NP;
endfunction

// payload credits beyond a 4 dword header, one per 4 dwords
function automatic data_credit_t data_credits(input int n_dw);
  return (n_dw > 4) ? data_credit_t'((n_dw - 4) / 4) : '0;
endfunction

// low 2 bytes of the sequence beat, then every TLP dword
function automatic logic [31:0] frame_lcrc(input logic [SEQ_BITS-1:0] seq, input int n_dw);
  logic [31:0] crc;
  crc = '1;
  crc = crc32_dw(crc, {20'h0, seq}, 2);
  for (int i = 0; i < n_dw; i++) begin
    crc = crc32_dw(crc, frame_dw[i], 4);
  end
  return ~crc;
endfunction

task automatic push_dllp(input dllp_u body);
  dllp_u crc_word;
  crc_word = {16'h0, crc16_dw(body)};
  exp_dllp_data.push_back(body);
  exp_dllp_keep.push_back(4'hF);
  exp_dllp_last.push_back(1'b0);
  exp_dllp_data.push_back(crc_word);
  exp_dllp_keep.push_back(4'h3);
  exp_dllp_last.push_back(1'b1);
endtask

task automatic expect_good_frame(input logic [SEQ_BITS-1:0] seq, input int n_dw);
  dllp_u        body;
  tlp_class_e   cls;
  data_credit_t dc;
  for (int i = 0; i < n_dw; i++) begin
    exp_tlp_data.push_back(frame_dw[i]);
    exp_tlp_last.push_back(i == n_dw - 1);
  end
  cls = class_of(frame_dw[0][31:24]);
  dc = data_credits(n_dw);
  body = '0;
  body.ack.dllp_type = DLLP_ACK;
  body.ack.seq = seq;
  push_dllp(body);
  body = '0;
  if (cls == CLASS_P) begin
    model_ph = model_ph + 1'b1;
    model_pd = model_pd + dc;
    body.fc.dllp_type = DLLP_FC_P;
    body.fc.hdr_fc = model_ph + FC_HDR_INIT;
    body.fc.data_fc = model_pd + FC_DATA_INIT;
    push_dllp(body);
  end else if (cls == CLASS_NP) begin
    model_nph = model_nph + 1'b1;
    model_npd = model_npd + dc;
    body.fc.dllp_type = DLLP_FC_NP;
    body.fc.hdr_fc = model_nph + FC_HDR_INIT;
    body.fc.data_fc = model_npd + FC_DATA_INIT;
    push_dllp(body);
  end
  model_seq = model_seq + 1'b1;
endtask

task automatic check_tlp_beat(input logic [DW_BITS-1:0] got_data, input logic got_last);
  logic [DW_BITS-1:0] want_data;
  logic               want_last;
  if (exp_tlp_data.size() == 0) begin
    abort_run("TLP beat transferred while no frame was expected");
  end else begin
    want_data = exp_tlp_data.pop_front();
    want_last = exp_tlp_last.pop_front();
    if (got_data !== want_data) begin
      abort_run($sformatf("[FAIL] m_tlp_data_o expected %08h got %08h", want_data, got_data));
    end
    if (got_last !== want_last) begin
      abort_run($sformatf("[FAIL] m_tlp_last_o expected %0h got %0h", want_last, got_last));
    end
  end
endtask

task automatic check_dllp_beat(input dllp_u got_data, input logic [3:0] got_keep,
                               input logic got_last);
  dllp_u      want_data;
  logic [3:0] want_keep;
  logic       want_last;
  if (exp_dllp_data.size() == 0) begin
    abort_run("DLLP beat transferred while none was expected");
  end else begin
    want_data = exp_dllp_data.pop_front();
    want_keep = exp_dllp_keep.pop_front();
    want_last = exp_dllp_last.pop_front();
    if (got_data !== want_data) begin
      abort_run($sformatf("[FAIL] m_dllp_data_o expected %08h got %08h", want_data, got_data));
    end
    if (got_keep !== want_keep) begin
      abort_run($sformatf("[FAIL] m_dllp_keep_o expected %0h got %0h", want_keep, got_keep));
    end
    if (got_last !== want_last) begin
      abort_run($sformatf("[FAIL] m_dllp_last_o expected %0h got %0h", want_last, got_last));
    end
  end
endtask

/* sim/dl_rx_tb.sv */
`timescale 1ns/10ps

module dl_rx_tb
  import pcie_dl_pkg::*;
();

  localparam int NUM_FRAMES    = 160;
  localparam int BEAT_TIMEOUT  = 1000;
  localparam int DRAIN_TIMEOUT = 5000;

  logic               clk_i;
  logic               rst_i;
  logic               link_up_i;
  logic [DW_BITS-1:0] s_data_i;
  logic               s_valid_i;
  logic               s_last_i;
  logic               s_ready_o;
  logic [DW_BITS-1:0] m_tlp_data_o;
  logic               m_tlp_valid_o;
  logic               m_tlp_last_o;
  logic               m_tlp_ready_i;
  logic [DW_BITS-1:0] m_dllp_data_o;
  logic [3:0]         m_dllp_keep_o;
  logic               m_dllp_valid_o;
  logic               m_dllp_last_o;
  logic               m_dllp_ready_i;

  int                 seed;
  logic               hold_tlp;
  logic [7:0]         type_codes [9];
  logic [DW_BITS-1:0] frame_dw [MAX_TLP_DW];

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

`include "dl_rx_tb_model.svh"

  dl_rx_top dl_rx_top_i (
    .clk_i(clk_i), .rst_i(rst_i), .link_up_i(link_up_i),
    .s_data_i(s_data_i), .s_valid_i(s_valid_i), .s_last_i(s_last_i), .s_ready_o(s_ready_o),
    .m_tlp_data_o(m_tlp_data_o), .m_tlp_valid_o(m_tlp_valid_o),
    .m_tlp_last_o(m_tlp_last_o), .m_tlp_ready_i(m_tlp_ready_i),
    .m_dllp_data_o(m_dllp_data_o), .m_dllp_keep_o(m_dllp_keep_o),
    .m_dllp_valid_o(m_dllp_valid_o), .m_dllp_last_o(m_dllp_last_o),
    .m_dllp_ready_i(m_dllp_ready_i)
  );

  always #4 clk_i = ~clk_i;

  // random back-pressure, with a long tlp stall to fill the buffer
  always @(posedge clk_i) begin
    if (!rst_i) begin
      m_tlp_ready_i  <= !hold_tlp && (({$random(seed)} % 4) != 0);
      m_dllp_ready_i <= ({$random(seed)} % 4) != 0;
    end
  end

  // sampled at the falling edge where all outputs are stable
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (m_tlp_valid_o && m_tlp_ready_i) begin
        check_tlp_beat(m_tlp_data_o, m_tlp_last_o);
      end
      if (m_dllp_valid_o && m_dllp_ready_i) begin
        check_dllp_beat(m_dllp_data_o, m_dllp_keep_o, m_dllp_last_o);
      end
      if (link_up_i != LINK_ACTIVE && s_ready_o) begin
        abort_run("frame input is ready while the link is down");
      end
    end
  end

  task automatic drive_beat(input logic [DW_BITS-1:0] data, input logic last);
    int   waited;
    logic taken;
    if (({$random(seed)} % 4) == 0) begin
      s_valid_i <= 1'b0;
      repeat (1 + {$random(seed)} % 3) @(posedge clk_i);
    end
    s_data_i  <= data;
    s_valid_i <= 1'b1;
    s_last_i  <= last;
    waited = 0;
    taken = 1'b0;
    while (!taken && waited < BEAT_TIMEOUT) begin
      @(negedge clk_i);
      taken = s_ready_o;
      waited++;
    end
    if (!taken) begin
      abort_run("input beat was not accepted before the timeout");
    end
    @(posedge clk_i);
  endtask

  task automatic send_random_frame();
    int                  n_dw;
    logic [SEQ_BITS-1:0] seq;
    logic [31:0]         lcrc;
    logic [31:0]         rnd;
    logic                bad_lcrc;
    logic                bad_seq;
    n_dw = 3 + int'({$random(seed)} % 18);
    for (int i = 0; i < n_dw; i++) begin
      frame_dw[i] = $random(seed);
    end
    frame_dw[0][31:24] = type_codes[{$random(seed)} % 9];
    bad_lcrc = ({$random(seed)} % 8) == 0;
    bad_seq = ({$random(seed)} % 10) == 0;
    seq = bad_seq ? model_seq + SEQ_BITS'(1 + {$random(seed)} % 8) : model_seq;
    lcrc = frame_lcrc(seq, n_dw);
    if (bad_lcrc) begin
      lcrc = lcrc ^ (32'h1 << ({$random(seed)} % 32));
    end
    // upper half of the sequence beat is not part of the frame
    rnd = $random(seed);
    drive_beat({rnd[31:16], 4'h0, seq}, 1'b0);
    for (int i = 0; i < n_dw; i++) begin
      drive_beat(frame_dw[i], 1'b0);
    end
    drive_beat(lcrc, 1'b1);
    if (!bad_lcrc && !bad_seq) begin
      expect_good_frame(seq, n_dw);
    end
  endtask

  initial begin
    int waited;
    seed = 46782;
    clk_i = 1'b0;
    rst_i = 1'b1;
    link_up_i = 1'b0;
    s_data_i = '0;
    s_valid_i = 1'b0;
    s_last_i = 1'b0;
    m_tlp_ready_i = 1'b0;
    m_dllp_ready_i = 1'b0;
    hold_tlp = 1'b0;
    model_seq = '0;
    model_ph = '0;
    model_nph = '0;
    model_pd = '0;
    model_npd = '0;
    // posted, non-posted and completion fmt/type codes
    type_codes = '{TLP_MWR32, TLP_MWR64, TLP_MSG, 8'h00, 8'h20, 8'h04, 8'h44,
                   TLP_CPL, TLP_CPLD};
    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    if (s_ready_o || m_tlp_valid_o || m_dllp_valid_o) begin
      abort_run("ready or valid outputs are not low during reset");
    end
    @(posedge clk_i);
    rst_i <= 1'b0;
    link_up_i <= 1'b1;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      if (f == 40) begin
        // stall the TLP output long enough for every slot to fill
        fork
          begin
            hold_tlp <= 1'b1;
            repeat (400) @(posedge clk_i);
            hold_tlp <= 1'b0;
          end
        join_none
      end
      if (f == 90) begin
        fork
          begin
            link_up_i <= 1'b0;
            repeat (150) @(posedge clk_i);
            link_up_i <= 1'b1;
          end
        join_none
      end
      send_random_frame();
    end
    s_valid_i <= 1'b0;
    s_last_i <= 1'b0;
    waited = 0;
    while ((exp_tlp_data.size() != 0 || exp_dllp_data.size() != 0) && waited < DRAIN_TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    // idle time so that any extra beat still reaches the monitor
    repeat (40) @(posedge clk_i);
    if (exp_tlp_data.size() != 0 || exp_dllp_data.size() != 0) begin
      abort_run("expected TLP or DLLP beats never arrived");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

/* source/dl_rx_top.sv */
`timescale 1ns/10ps

module dl_rx_top
  import pcie_dl_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               link_up_i,
  input  logic [DW_BITS-1:0] s_data_i,
  input  logic               s_valid_i,
  input  logic               s_last_i,
  output logic               s_ready_o,
  output logic [DW_BITS-1:0] m_tlp_data_o,
  output logic               m_tlp_valid_o,
  output logic               m_tlp_last_o,
  input  logic               m_tlp_ready_i,
  output logic [DW_BITS-1:0] m_dllp_data_o,
  output logic [3:0]         m_dllp_keep_o,
  output logic               m_dllp_valid_o,
  output logic               m_dllp_last_o,
  input  logic               m_dllp_ready_i
);

  logic                     lcrc_clr;
  logic                     lcrc_upd;
  logic                     lcrc_half;
  logic [DW_BITS-1:0]       lcrc;
  logic                     wr_en;
  logic [RAM_ADDR_BITS-1:0] wr_addr;
  logic [DW_BITS-1:0]       wr_data;
  logic [RAM_ADDR_BITS-1:0] rd_addr;
  logic [DW_BITS-1:0]       rd_data;
  logic [SLOT_BITS-1:0]     tail;
  logic [SLOT_BITS-1:0]     head;
  logic                     ack_req;
  logic [SEQ_BITS-1:0]      ack_seq;
  tlp_class_e               ack_class;
  logic [WCOUNT_BITS-1:0]   ack_wcount;
  logic                     dllp_busy;

  dl_rx_framer dl_rx_framer_i (
    .clk_i(clk_i), .rst_i(rst_i), .link_up_i(link_up_i),
    .s_data_i(s_data_i), .s_valid_i(s_valid_i), .s_last_i(s_last_i),
    .lcrc_i(lcrc), .head_i(head), .dllp_busy_i(dllp_busy), .s_ready_o(s_ready_o),
    .lcrc_clr_o(lcrc_clr), .lcrc_upd_o(lcrc_upd), .lcrc_half_o(lcrc_half),
    .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data), .tail_o(tail),
    .ack_req_o(ack_req), .ack_seq_o(ack_seq), .ack_class_o(ack_class),
    .ack_wcount_o(ack_wcount)
  );

  lcrc32_accum lcrc32_accum_i (
    .clk_i(clk_i), .rst_i(rst_i), .clr_i(lcrc_clr), .upd_i(lcrc_upd),
    .half_i(lcrc_half), .data_i(s_data_i), .lcrc_o(lcrc)
  );

  dllp_builder dllp_builder_i (
    .clk_i(clk_i), .rst_i(rst_i), .req_i(ack_req), .seq_i(ack_seq),
    .class_i(ack_class), .wcount_i(ack_wcount), .m_dllp_ready_i(m_dllp_ready_i),
    .busy_o(dllp_busy), .m_dllp_data_o(m_dllp_data_o), .m_dllp_keep_o(m_dllp_keep_o),
    .m_dllp_valid_o(m_dllp_valid_o), .m_dllp_last_o(m_dllp_last_o)
  );

  rx_buffer_ram rx_buffer_ram_i (
    .clk_i(clk_i), .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
    .rd_addr_i(rd_addr), .rd_data_o(rd_data)
  );

  tlp_forwarder tlp_forwarder_i (
    .clk_i(clk_i), .rst_i(rst_i), .tail_i(tail), .rd_data_i(rd_data),
    .m_tlp_ready_i(m_tlp_ready_i), .head_o(head), .rd_addr_o(rd_addr),
    .m_tlp_data_o(m_tlp_data_o), .m_tlp_valid_o(m_tlp_valid_o),
    .m_tlp_last_o(m_tlp_last_o)
  );

endmodule

/* source/rx_buffer_ram.sv */
`timescale 1ns/10ps

module rx_buffer_ram
  import pcie_dl_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     wr_en_i,
  input  logic [RAM_ADDR_BITS-1:0] wr_addr_i,
  input  logic [DW_BITS-1:0]       wr_data_i,
  input  logic [RAM_ADDR_BITS-1:0] rd_addr_i,
  output logic [DW_BITS-1:0]       rd_data_o
);

  // slot s occupies words s*MAX_TLP_DW and up
  logic [DW_BITS-1:0] mem [SLOT_COUNT*MAX_TLP_DW];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_data_o <= mem[rd_addr_i];
  end

endmodule

/* source/tlp_forwarder.sv */
`timescale 1ns/10ps

module tlp_forwarder
  import pcie_dl_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic [SLOT_BITS-1:0]     tail_i,
  input  logic [DW_BITS-1:0]       rd_data_i,
  input  logic                     m_tlp_ready_i,
  output logic [SLOT_BITS-1:0]     head_o,
  output logic [RAM_ADDR_BITS-1:0] rd_addr_o,
  output logic [DW_BITS-1:0]       m_tlp_data_o,
  output logic                     m_tlp_valid_o,
  output logic                     m_tlp_last_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_READ_CNT, ST_STREAM} state_e;

  state_e                   state_q;
  logic [SLOT_BITS-1:0]     head_q;
  logic [WCOUNT_BITS-1:0]   beat_q;
  logic [WCOUNT_BITS-1:0]   count_q;
  logic [WCOUNT_BITS-1:0]   rd_off;
  logic [RAM_ADDR_BITS-1:0] slot_base;
  logic                     xfer;

  assign slot_base = RAM_ADDR_BITS'(head_q[SLOT_BITS-2:0]) * RAM_ADDR_BITS'(MAX_TLP_DW);
  assign xfer = m_tlp_valid_o && m_tlp_ready_i;

  // read ahead one dword so the next beat is ready after a transfer
  always_comb begin
    case (state_q)
      ST_IDLE: rd_off = '0;
      ST_READ_CNT: rd_off = WCOUNT_BITS'(1);
      default: rd_off = m_tlp_ready_i ? beat_q + 1'b1 : beat_q;
    endcase
  end

  assign rd_addr_o     = slot_base + RAM_ADDR_BITS'(rd_off);
  assign head_o        = head_q;
  assign m_tlp_data_o  = rd_data_i;
  assign m_tlp_valid_o = (state_q == ST_STREAM);
  assign m_tlp_last_o  = m_tlp_valid_o && (beat_q == count_q);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      head_q  <= '0;
      beat_q  <= '0;
      count_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: if (head_q != tail_i) state_q <= ST_READ_CNT;
        ST_READ_CNT: begin
          // count word from offset 0 is on the read port now
          count_q <= rd_data_i[WCOUNT_BITS-1:0];
          beat_q  <= WCOUNT_BITS'(1);
          state_q <= ST_STREAM;
        end
        default: begin
          if (xfer) begin
            beat_q <= beat_q + 1'b1;
            if (m_tlp_last_o) begin
              head_q  <= head_q + 1'b1;
              state_q <= ST_IDLE;
            end
          end
        end
      endcase
    end
  end

endmodule
